//--- project.f
+incdir+include
rtl/memPkg.sv
rtl/fetchIf.sv
rtl/dataReqIf.sv
rtl/ramBusIf.sv
rtl/byteRam.sv
rtl/memCtrl.sv
rtl/memSubsys.sv
bench/memSubsysTb.sv

//--- Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/memPkg.sv
      - rtl/fetchIf.sv
      - rtl/dataReqIf.sv
      - rtl/ramBusIf.sv
      - rtl/byteRam.sv
      - rtl/memCtrl.sv
      - rtl/memSubsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/memSubsysTb.sv

//--- bench/memSubsysTb.sv
`timescale 1ns/10ps
`include "memCtrl_config.svh"

module memSubsysTb import memPkg::*; ();

    localparam int SeedInit = 70;
    localparam int NumLoads = 40;
    localparam int NumOps = 12;
    localparam int TimeoutCycles = 50;
    localparam int RegionBase = 'h1000;
    localparam int RegionBytes = 256;

    logic       clk = 1'b0;
    logic       rst;
    logic       ioBufferFull;
    logic       fetchReq;
    addr_t      fetchAddr;
    logic       fetchAck;
    word_t      fetchInst;
    logic       dataReq;
    memOp_e     dataOp;
    accessLen_e dataLen;
    addr_t      dataAddr;
    word_t      dataWdata;
    logic       dataAck;
    word_t      dataRdata;

    byte_t model [2**`MEM_ADDR_WIDTH];
    int    seed;
    int    checkCount = 0;
    int    errorCount = 0;

    always #4 clk = ~clk;

    memSubsys memSubsys_inst (.*);

    task automatic checkData(input word_t got, input word_t exp, input string msg);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t: %s, rdata %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic checkInst(input word_t got, input word_t exp, input string msg);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t: %s, inst %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic checkIdle(input logic ack, input string msg);
        checkCount++;
        if (ack !== 1'b0) begin
            errorCount++;
            $display("FAILED at %0t: %s, ack is %b", $time, msg, ack);
        end
    endtask

    task automatic reportTimeout(input string what);
        errorCount++;
        $display("timeout: %s within %0d cycles", what, TimeoutCycles);
    endtask

    // little-endian with the bytes above the access length left zero
    function automatic word_t modelRead(input addr_t a, input accessLen_e n);
        word_t w;
        w = '0;
        for (int k = 0; k < int'(n); k++) begin
            w[`MEM_BYTE_WIDTH*k +: `MEM_BYTE_WIDTH] = model[a + addr_t'(k)];
        end
        return w;
    endfunction

    task automatic modelWrite(input addr_t a, input accessLen_e n, input word_t w);
        for (int k = 0; k < int'(n); k++) begin
            model[a + addr_t'(k)] = w[`MEM_BYTE_WIDTH*k +: `MEM_BYTE_WIDTH];
        end
    endtask

    // keeps a word access inside the written region
    function automatic addr_t randAddr();
        return addr_t'(RegionBase + {$random(seed)} % (RegionBytes - 3));
    endfunction

    function automatic accessLen_e randLen();
        case ({$random(seed)} % 3)
            0: return lenByte;
            1: return lenHalf;
            default: return lenWord;
        endcase
    endfunction

    task automatic startData(input memOp_e op, input accessLen_e n, input addr_t a,
                             input word_t w);
        dataReq   = 1'b1;
        dataOp    = op;
        dataLen   = n;
        dataAddr  = a;
        dataWdata = w;
    endtask

    task automatic finishData(output word_t rdata);
        int waitCnt;
        waitCnt = 0;
        while (dataAck !== 1'b1 && waitCnt < TimeoutCycles) begin
            @(negedge clk);
            waitCnt++;
        end
        if (dataAck !== 1'b1) begin
            reportTimeout("data port never raised ack");
        end else begin
            checkIdle(fetchAck, "fetch ack high together with data ack");
            rdata   = dataRdata;
            dataReq = 1'b0;
            waitCnt = 0;
            while (dataAck !== 1'b0 && waitCnt < TimeoutCycles) begin
                @(negedge clk);
                waitCnt++;
            end
            if (dataAck !== 1'b0) begin
                reportTimeout("data port never dropped ack");
            end
        end
    endtask

    task automatic finishFetch(output word_t inst);
        int waitCnt;
        waitCnt = 0;
        while (fetchAck !== 1'b1 && waitCnt < TimeoutCycles) begin
            @(negedge clk);
            waitCnt++;
        end
        if (fetchAck !== 1'b1) begin
            reportTimeout("fetch port never raised ack");
        end else begin
            inst     = fetchInst;
            fetchReq = 1'b0;
            waitCnt  = 0;
            while (fetchAck !== 1'b0 && waitCnt < TimeoutCycles) begin
                @(negedge clk);
                waitCnt++;
            end
            if (fetchAck !== 1'b0) begin
                reportTimeout("fetch port never dropped ack");
            end
        end
    endtask

    task automatic storeData(input addr_t a, input accessLen_e n, input word_t w);
        word_t unused;
        startData(opStore, n, a, w);
        finishData(unused);
        modelWrite(a, n, w);
    endtask

    task automatic loadCheck(input addr_t a, input accessLen_e n, input string msg);
        word_t r;
        startData(opLoad, n, a, '0);
        finishData(r);
        checkData(r, modelRead(a, n), msg);
    endtask

    // starts one edge after the request is seen
    task automatic stallFor(input int cycles);
        @(negedge clk);
        ioBufferFull = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            checkIdle(fetchAck, "fetch ack during stall");
            checkIdle(dataAck, "data ack during stall");
        end
        ioBufferFull = 1'b0;
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("test %s: %0d errors", name, errorCount - errBefore);
    endtask

    initial begin
        int         errBefore;
        word_t      r;
        word_t      w;
        addr_t      a;
        addr_t      b;
        accessLen_e n;
        int         stall;
        seed         = SeedInit;
        rst          = 1'b1;
        ioBufferFull = 1'b0;
        fetchReq     = 1'b0;
        fetchAddr    = '0;
        dataReq      = 1'b0;
        dataOp       = opLoad;
        dataLen      = lenWord;
        dataAddr     = '0;
        dataWdata    = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        errBefore = errorCount;
        repeat (10) begin
            @(negedge clk);
            checkIdle(fetchAck, "fetch ack without request");
            checkIdle(dataAck, "data ack without request");
        end
        reportTest("1 idle after reset", errBefore);

        errBefore = errorCount;
        for (int i = 0; i < RegionBytes / 4; i++) begin
            storeData(addr_t'(RegionBase + 4 * i), lenWord, $random(seed));
        end
        for (int i = 0; i < NumLoads; i++) begin
            loadCheck(randAddr(), randLen(), "random load");
        end
        reportTest("2 word stores and random loads", errBefore);

        errBefore = errorCount;
        for (int i = 0; i < NumOps; i++) begin
            a = randAddr();
            n = ({$random(seed)} % 2) ? lenHalf : lenByte;
            storeData(a, n, $random(seed));
            loadCheck(a, lenWord, "word load after short store");
        end
        reportTest("3 byte and half stores", errBefore);

        errBefore = errorCount;
        for (int i = 0; i < NumOps; i++) begin
            a = randAddr();
            fetchReq  = 1'b1;
            fetchAddr = a;
            finishFetch(r);
            checkInst(r, modelRead(a, lenWord), "random fetch");
        end
        reportTest("4 fetches", errBefore);

        // both requests on one edge with the data port served first
        errBefore = errorCount;
        for (int i = 0; i < 4; i++) begin
            a = randAddr();
            b = randAddr();
            fetchReq  = 1'b1;
            fetchAddr = a;
            startData(opLoad, lenWord, b, '0);
            finishData(r);
            checkData(r, modelRead(b, lenWord), "load in tie");
            finishFetch(r);
            checkInst(r, modelRead(a, lenWord), "fetch in tie");
        end
        reportTest("5 arbitration", errBefore);

        errBefore = errorCount;
        for (int i = 0; i < NumOps; i++) begin
            a     = randAddr();
            stall = 2 + {$random(seed)} % 9;
            case ({$random(seed)} % 3)
                0: begin
                    startData(opLoad, lenWord, a, '0);
                    stallFor(stall);
                    finishData(r);
                    checkData(r, modelRead(a, lenWord), "stalled load");
                end
                1: begin
                    w = $random(seed);
                    startData(opStore, lenWord, a, w);
                    stallFor(stall);
                    finishData(r);
                    modelWrite(a, lenWord, w);
                    loadCheck(a, lenWord, "load after stalled store");
                end
                default: begin
                    fetchReq  = 1'b1;
                    fetchAddr = a;
                    stallFor(stall);
                    finishFetch(r);
                    checkInst(r, modelRead(a, lenWord), "stalled fetch");
                end
            endcase
        end
        reportTest("6 io buffer stalls", errBefore);

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/memSubsys.sv
`timescale 1ns/10ps

module memSubsys import memPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ioBufferFull,

    input  logic       fetchReq,
    input  addr_t      fetchAddr,
    output logic       fetchAck,
    output word_t      fetchInst,

    input  logic       dataReq,
    input  memOp_e     dataOp,
    input  accessLen_e dataLen,
    input  addr_t      dataAddr,
    input  word_t      dataWdata,
    output logic       dataAck,
    output word_t      dataRdata
);

    fetchIf   fetchBus ();
    dataReqIf dataBus ();
    ramBusIf  ramBus ();

    assign fetchBus.req  = fetchReq;
    assign fetchBus.addr = fetchAddr;
    assign fetchAck      = fetchBus.ack;
    assign fetchInst     = fetchBus.inst;

    assign dataBus.req   = dataReq;
    assign dataBus.op    = dataOp;
    assign dataBus.len   = dataLen;
    assign dataBus.addr  = dataAddr;
    assign dataBus.wdata = dataWdata;
    assign dataAck       = dataBus.ack;
    assign dataRdata     = dataBus.rdata;

    memCtrl memCtrlInst (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .fetch        (fetchBus.ctrl),
        .data         (dataBus.ctrl),
        .ram          (ramBus.ctrl)
    );

    byteRam byteRamInst (
        .clk (clk),
        .rst (rst),
        .bus (ramBus.ram)
    );

endmodule

//--- rtl/memCtrl.sv
`timescale 1ns/10ps
`include "memCtrl_config.svh"

module memCtrl import memPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   ioBufferFull,
    fetchIf.ctrl   fetch,
    dataReqIf.ctrl data,
    ramBusIf.ctrl  ram
);

    ctrlState_e state;

    // bytes addressed so far in a read, bytes written so far in a store
    logic [2:0] cnt;
    logic [1:0] rdIdx;

    addr_t      baseAddr;
    accessLen_e len;
    word_t      wdataReg;
    word_t      asmWord;

    // 1 when the data port owns the current access
    logic dataSel;
    logic fetchAck;
    logic dataAck;
    logic curReq;
    logic curAck;

    // byte currently sitting in ram.rdata
    assign rdIdx = 2'(cnt - 3'd1);

    assign curReq = dataSel ? data.req : fetch.req;
    assign curAck = dataSel ? dataAck : fetchAck;

    assign fetch.ack  = fetchAck;
    assign data.ack   = dataAck;
    assign fetch.inst = asmWord;
    assign data.rdata = asmWord;

    always_comb begin
        ram.we    = 1'b0;
        ram.wdata = wdataReg[`MEM_BYTE_WIDTH*cnt[1:0] +: `MEM_BYTE_WIDTH];
        case (state)
            stIdle: begin
                // byte 0 goes out on the same edge the request is seen
                ram.addr = data.req ? data.addr : fetch.addr;
            end
            stFetch, stLoad: begin
                // on a stall, re-read the byte already in flight
                if (ioBufferFull) begin
                    ram.addr = baseAddr + addr_t'(rdIdx);
                end else begin
                    ram.addr = baseAddr + addr_t'(cnt);
                end
            end
            stStore: begin
                ram.addr = baseAddr + addr_t'(cnt);
                ram.we   = !ioBufferFull;
            end
            default: begin
                ram.addr = baseAddr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= stIdle;
            cnt      <= '0;
            dataSel  <= 1'b0;
            fetchAck <= 1'b0;
            dataAck  <= 1'b0;
        end else if (!ioBufferFull) begin
            case (state)
                stIdle: begin
                    // data port wins a tie
                    if (data.req) begin
                        dataSel <= 1'b1;
                        if (data.op == opStore) begin
                            state <= stStore;
                            cnt   <= 3'd0;
                        end else begin
                            state <= stLoad;
                            cnt   <= 3'd1;
                        end
                    end else if (fetch.req) begin
                        dataSel <= 1'b0;
                        state   <= stFetch;
                        cnt     <= 3'd1;
                    end
                end
                stFetch, stLoad: begin
                    if (cnt == len) begin
                        state <= stAck;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                stStore: begin
                    if (cnt == len - 3'd1) begin
                        state <= stAck;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                stAck: begin
                    if (!curAck) begin
                        fetchAck <= !dataSel;
                        dataAck  <= dataSel;
                    end else if (!curReq) begin
                        // four-phase close, ack drops a cycle after req
                        fetchAck <= 1'b0;
                        dataAck  <= 1'b0;
                        state    <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // request fields and the assembled word
    always_ff @(posedge clk) begin
        if (!ioBufferFull) begin
            if (state == stIdle) begin
                baseAddr <= data.req ? data.addr : fetch.addr;
                len      <= data.req ? data.len : lenWord;
                wdataReg <= data.wdata;
                // cleared so short loads come out zero-extended
                asmWord  <= '0;
            end else if (state == stFetch || state == stLoad) begin
                asmWord[`MEM_BYTE_WIDTH*rdIdx +: `MEM_BYTE_WIDTH] <= ram.rdata;
            end
        end
    end

endmodule

//--- rtl/byteRam.sv
`timescale 1ns/10ps
`include "memCtrl_config.svh"

module byteRam import memPkg::*; #(
    parameter int AddrWidth = `MEM_ADDR_WIDTH
) (
    input logic  clk,
    input logic  rst,
    ramBusIf.ram bus
);

    byte_t mem [2**AddrWidth];

    logic [AddrWidth-1:0] index;

    // upper address bits ignored for a smaller RAM
    assign index = bus.addr[AddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[index] <= bus.wdata;
        end
    end

    // one cycle read latency, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.rdata <= '0;
        end else begin
            bus.rdata <= mem[index];
        end
    end

endmodule

//--- rtl/ramBusIf.sv
`timescale 1ns/10ps

interface ramBusIf import memPkg::*; ();
    addr_t addr;
    logic  we;
    byte_t wdata;
    byte_t rdata;

    modport ctrl (
        output addr,
        output we,
        output wdata,
        input  rdata
    );

    modport ram (input addr, input we, input wdata, output rdata);
endinterface

//--- rtl/dataReqIf.sv
`timescale 1ns/10ps

interface dataReqIf import memPkg::*; ();
    logic       req;
    logic       ack;
    memOp_e     op;
    accessLen_e len;
    addr_t      addr;
    word_t      wdata;
    word_t      rdata;

    modport client (
        output req,
        output op,
        output len,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport ctrl (
        input  req,
        input  op,
        input  len,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );
endinterface

//--- rtl/fetchIf.sv
`timescale 1ns/10ps

interface fetchIf import memPkg::*; ();
    logic  req;
    logic  ack;
    addr_t addr;
    word_t inst;

    modport client (
        output req,
        output addr,
        input  ack,
        input  inst
    );

    modport ctrl (
        input  req,
        input  addr,
        output ack,
        output inst
    );
endinterface

//--- rtl/memPkg.sv
`include "memCtrl_config.svh"

package memPkg;

    typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MEM_WORD_WIDTH-1:0] word_t;
    typedef logic [`MEM_BYTE_WIDTH-1:0] byte_t;

    typedef enum logic {
        opLoad,
        opStore
    } memOp_e;

    // value is the number of bytes moved
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen_e;

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stLoad,
        stStore,
        stAck
    } ctrlState_e;

endpackage

//--- include/memCtrl_config.svh
`ifndef MEM_CTRL_CONFIG_SVH
`define MEM_CTRL_CONFIG_SVH

// byte address width, 128 KiB of RAM
`define MEM_ADDR_WIDTH 17

// width of an instruction or a data word
`define MEM_WORD_WIDTH 32

// one RAM location
`define MEM_BYTE_WIDTH 8

`endif
